// File: Bender.yml
package:
  name: dll_track

sources:
  - logic/loop_cfg_pkg.sv
  - logic/hs_pkg.sv
  - logic/sample_bus_if.sv
  - logic/code_bus_if.sv
  - logic/sample_dispatch.sv
  - logic/step_fsm.sv
  - logic/delay_lane.sv
  - logic/code_collect.sv
  - logic/dll_track_top.sv
  - target: test
    files:
      - verif/dll_track_chk.sv
      - verif/dll_track_tb.sv

// File: logic/code_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface code_bus_if import loop_cfg_pkg::*; ();

    // ****************************************
    // one slot per lane
    // ****************************************
    logic [CODE_W-1:0] codes    [LANES];
    logic              settling [LANES];

    // each lane writes only its own slot
    modport lane (output codes, output settling);

    modport collect (input codes, input settling);

endinterface

`default_nettype wire

// File: logic/code_collect.sv
`timescale 1ns/1ps
`default_nettype none

module code_collect import loop_cfg_pkg::*, hs_pkg::*; (
    input  logic              phi1,
    input  logic              reset_lin_s1,
    sample_bus_if.collect     sbus,
    code_bus_if.collect       cbus,
    output logic [CODE_W-1:0] code_out_s1,
    output logic [1:0]        lane_out_s1,
    output logic              settle_out_s1,
    output logic              out_req_s1,
    input  logic              out_ack_s1
);

    logic      ack_meta;
    logic      ack_sync;
    tx_state_e state_q;
    tx_state_e state_d;
    logic [1:0] lane_q;
    logic      last_lane;

    assign last_lane = (lane_q == 2'(LANES - 1));

    // two-flop synchronizer on the acknowledge
    always_ff @(posedge phi1)
    begin
        if (reset_lin_s1)
        begin
            ack_meta <= 1'b0;
            ack_sync <= 1'b0;
        end
        else
        begin
            ack_meta <= out_ack_s1;
            ack_sync <= ack_meta;
        end
    end

    // ****************************************
    // lane walk
    // ****************************************
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            TX_IDLE:    if (sbus.update) state_d = TX_REQ;
            TX_REQ:     state_d = TX_RELEASE;
            TX_RELEASE: if (ack_sync) state_d = TX_NEXT;
            TX_NEXT:    if (!ack_sync) state_d = last_lane ? TX_IDLE : TX_REQ;
            default:    state_d = TX_IDLE;
        endcase
    end

    always_ff @(posedge phi1)
    begin
        if (reset_lin_s1)
        begin
            state_q    <= TX_IDLE;
            lane_q     <= '0;
            out_req_s1 <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if ((state_q == TX_IDLE) && sbus.update)
                lane_q <= '0;
            if (state_q == TX_REQ)
                out_req_s1 <= 1'b1;
            if ((state_q == TX_RELEASE) && ack_sync)
                out_req_s1 <= 1'b0;
            if ((state_q == TX_NEXT) && !ack_sync && !last_lane)
                lane_q <= lane_q + 2'd1;
        end
    end

    // data loads with the rise of the request
    always_ff @(posedge phi1)
    begin
        if (state_q == TX_REQ)
        begin
            code_out_s1   <= cbus.codes[lane_q];
            settle_out_s1 <= cbus.settling[lane_q];
        end
    end

    assign lane_out_s1 = lane_q;

    assign sbus.round_done = (state_q == TX_NEXT) && !ack_sync && last_lane;

endmodule

`default_nettype wire

// File: logic/delay_lane.sv
`timescale 1ns/1ps
`default_nettype none

module delay_lane import loop_cfg_pkg::*; #(
    parameter int lane_idx = 0
) (
    input  logic       phi1,
    input  logic       reset_lin_s1,
    sample_bus_if.lane sbus,
    code_bus_if.lane   cbus
);

    logic signed [STEP_W-1:0]   step;
    logic                       settling;
    logic signed [CODE_W+1:0]   sum;
    logic        [CODE_W-1:0]   code_d;
    logic        [CODE_W-1:0]   code_q;
    logic                       settle_q;

    step_fsm u_fsm (
        .phi1         (phi1),
        .reset_lin_s1 (reset_lin_s1),
        .advance      (sbus.update),
        .up           (sbus.up_bits[lane_idx]),
        .step         (step),
        .settling     (settling)
    );

    // two guard bits catch under- and overflow
    always_comb
    begin
        sum = $signed({2'b00, code_q}) + step;
        if (sum[CODE_W+1])
            code_d = '0;
        else if (sum[CODE_W])
            code_d = '1;
        else
            code_d = sum[CODE_W-1:0];
    end

    // settle flag belongs to the state that ran this round
    always_ff @(posedge phi1)
    begin
        if (reset_lin_s1)
        begin
            code_q   <= CODE_INIT;
            settle_q <= 1'b0;
        end
        else if (sbus.update)
        begin
            code_q   <= code_d;
            settle_q <= settling;
        end
    end

    assign cbus.codes[lane_idx]    = code_q;
    assign cbus.settling[lane_idx] = settle_q;

endmodule

`default_nettype wire

// File: logic/dll_track_top.sv
`timescale 1ns/1ps
`default_nettype none

module dll_track_top import loop_cfg_pkg::*; (
    input  logic              phi1,
    input  logic              reset_lin_s1,
    input  logic              in_req_s1,
    input  logic [LANES-1:0]  up_in_s1,
    output logic              in_ack_s1,
    output logic [CODE_W-1:0] code_out_s1,
    output logic [1:0]        lane_out_s1,
    output logic              settle_out_s1,
    output logic              out_req_s1,
    input  logic              out_ack_s1
);

    sample_bus_if sbus ();
    code_bus_if   cbus ();

    sample_dispatch u_dispatch (
        .phi1         (phi1),
        .reset_lin_s1 (reset_lin_s1),
        .in_req_s1    (in_req_s1),
        .up_in_s1     (up_in_s1),
        .in_ack_s1    (in_ack_s1),
        .bus          (sbus)
    );

    // one tracking lane per phase detector output
    generate
        for (genvar i = 0; i < LANES; i++)
        begin : g_lane
            delay_lane #(
                .lane_idx (i)
            ) u_lane (
                .phi1         (phi1),
                .reset_lin_s1 (reset_lin_s1),
                .sbus         (sbus),
                .cbus         (cbus)
            );
        end
    endgenerate

    code_collect u_collect (
        .phi1          (phi1),
        .reset_lin_s1  (reset_lin_s1),
        .sbus          (sbus),
        .cbus          (cbus),
        .code_out_s1   (code_out_s1),
        .lane_out_s1   (lane_out_s1),
        .settle_out_s1 (settle_out_s1),
        .out_req_s1    (out_req_s1),
        .out_ack_s1    (out_ack_s1)
    );

endmodule

`default_nettype wire

// File: logic/hs_pkg.sv
`default_nettype none

package hs_pkg;

    // input link receiver
    typedef enum logic [1:0] {
        RX_IDLE       = 2'd0,
        RX_UPDATE     = 2'd1,
        RX_WAIT_ROUND = 2'd2,
        RX_ACK        = 2'd3
    } rx_state_e;

    // output link sender, one pass per lane
    typedef enum logic [1:0] {
        TX_IDLE    = 2'd0,
        TX_REQ     = 2'd1,
        TX_RELEASE = 2'd2,
        TX_NEXT    = 2'd3
    } tx_state_e;

endpackage

`default_nettype wire

// File: logic/loop_cfg_pkg.sv
`default_nettype none

package loop_cfg_pkg;

    // ****************************************
    // loop sizes
    // ****************************************
    localparam int LANES  = 4;
    localparam int CODE_W = 7;
    localparam int STEP_W = 6;

    // mid-range start point of the delay line
    localparam logic [CODE_W-1:0] CODE_INIT = 7'd64;

    // step magnitudes, coarse to fine
    localparam logic signed [STEP_W-1:0] STEP_BIN1 = 6'sd16;
    localparam logic signed [STEP_W-1:0] STEP_BIN2 = 6'sd8;
    localparam logic signed [STEP_W-1:0] STEP_BIN3 = 6'sd4;
    localparam logic signed [STEP_W-1:0] STEP_LIN  = 6'sd1;

    // samples spent settling after each step
    localparam int IDLE_LEN = 4;

    // ****************************************
    // lane step state
    // ****************************************
    typedef enum logic [3:0] {
        BIN_0  = 4'd0,
        BIN_1  = 4'd1,
        BIN_2  = 4'd2,
        BIN_3  = 4'd3,
        LIN    = 4'd4,
        IDLE_0 = 4'd5,
        IDLE_1 = 4'd6,
        IDLE_2 = 4'd7,
        IDLE_3 = 4'd8
    } step_state_e;

endpackage

`default_nettype wire

// File: logic/sample_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sample_bus_if import loop_cfg_pkg::*; ();

    // one pulse per accepted sample word
    logic             update;
    // phase detector decisions, one per lane
    logic [LANES-1:0] up_bits;
    // all lanes delivered on the output link
    logic             round_done;

    modport dispatch (output update, output up_bits, input round_done);

    modport lane (input update, input up_bits);

    modport collect (input update, output round_done);

endinterface

`default_nettype wire

// File: logic/sample_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module sample_dispatch import loop_cfg_pkg::*, hs_pkg::*; (
    input  logic             phi1,
    input  logic             reset_lin_s1,
    input  logic             in_req_s1,
    input  logic [LANES-1:0] up_in_s1,
    output logic             in_ack_s1,
    sample_bus_if.dispatch   bus
);

    logic      req_meta;
    logic      req_sync;
    rx_state_e state_q;
    rx_state_e state_d;

    // two-flop synchronizer on the request
    always_ff @(posedge phi1)
    begin
        if (reset_lin_s1)
        begin
            req_meta <= 1'b0;
            req_sync <= 1'b0;
        end
        else
        begin
            req_meta <= in_req_s1;
            req_sync <= req_meta;
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            RX_IDLE:
                if (req_sync)
                    state_d = RX_UPDATE;
            RX_UPDATE:
                state_d = RX_WAIT_ROUND;
            RX_WAIT_ROUND:
                if (bus.round_done)
                    state_d = RX_ACK;
            // return to zero once the request has dropped
            RX_ACK:
                if (!req_sync)
                    state_d = RX_IDLE;
            default:
                state_d = RX_IDLE;
        endcase
    end

    always_ff @(posedge phi1)
    begin
        if (reset_lin_s1)
            state_q <= RX_IDLE;
        else
            state_q <= state_d;
    end

    // sample word is stable while the request is high
    always_ff @(posedge phi1)
    begin
        if ((state_q == RX_IDLE) && req_sync)
            bus.up_bits <= up_in_s1;
    end

    assign bus.update = (state_q == RX_UPDATE);

    // drops as soon as the synced request does
    assign in_ack_s1 = (state_q == RX_ACK) && req_sync;

endmodule

`default_nettype wire

// File: logic/step_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module step_fsm import loop_cfg_pkg::*; (
    input  logic                     phi1,
    input  logic                     reset_lin_s1,
    input  logic                     advance,
    input  logic                     up,
    output logic signed [STEP_W-1:0] step,
    output logic                     settling
);

    // last settling state before the pending step
    localparam step_state_e IDLE_LAST = step_state_e'(IDLE_0 + IDLE_LEN - 1);

    step_state_e state_q;
    step_state_e state_d;
    step_state_e pend_q;
    step_state_e pend_d;

    // ****************************************
    // next state
    // ****************************************
    always_comb
    begin
        state_d = state_q;
        pend_d  = pend_q;
        case (state_q)
            // start state, zero step needs no settling
            BIN_0:
                state_d = BIN_1;
            BIN_1:
            begin
                state_d = IDLE_0;
                pend_d  = BIN_2;
            end
            BIN_2:
            begin
                state_d = IDLE_0;
                pend_d  = BIN_3;
            end
            BIN_3:
            begin
                state_d = IDLE_0;
                pend_d  = LIN;
            end
            LIN:
            begin
                state_d = IDLE_0;
                pend_d  = LIN;
            end
            IDLE_0, IDLE_1, IDLE_2, IDLE_3:
            begin
                if (state_q == IDLE_LAST)
                    state_d = pend_q;
                else
                    state_d = step_state_e'(state_q + 4'd1);
            end
            default:
                state_d = LIN;
        endcase
    end

    always_ff @(posedge phi1)
    begin
        if (reset_lin_s1)
        begin
            state_q <= BIN_0;
            pend_q  <= BIN_1;
        end
        else if (advance)
        begin
            state_q <= state_d;
            pend_q  <= pend_d;
        end
    end

    // output decoder, sign taken from up
    always_comb
    begin
        step     = '0;
        settling = 1'b0;
        case (state_q)
            BIN_1:  step = up ? STEP_BIN1 : -STEP_BIN1;
            BIN_2:  step = up ? STEP_BIN2 : -STEP_BIN2;
            BIN_3:  step = up ? STEP_BIN3 : -STEP_BIN3;
            LIN:    step = up ? STEP_LIN  : -STEP_LIN;
            IDLE_0, IDLE_1, IDLE_2, IDLE_3:
                settling = 1'b1;
            default:
                step = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verif/dll_track_chk.sv
`timescale 1ns/1ps
`default_nettype none

module dll_track_chk import loop_cfg_pkg::*; (
    input logic              phi1,
    input logic              reset_lin_s1,
    input logic              in_req_s1,
    input logic              in_ack_s1,
    input logic [CODE_W-1:0] code_out_s1,
    input logic [1:0]        lane_out_s1,
    input logic              out_req_s1,
    input logic              out_ack_s1
);

    // request held until the sink answers
    a_req_held: assert property (@(posedge phi1) disable iff (reset_lin_s1)
        out_req_s1 && !out_ack_s1 |=> out_req_s1)
        else $error("out_req_s1 fell before out_ack_s1 was high");

    // lane data frozen while offered
    a_data_stable: assert property (@(posedge phi1) disable iff (reset_lin_s1)
        out_req_s1 && $past(out_req_s1) |-> $stable(code_out_s1) && $stable(lane_out_s1))
        else $error("output link data changed while out_req_s1 was high");

    a_ack_needs_req: assert property (@(posedge phi1) disable iff (reset_lin_s1)
        $rose(in_ack_s1) |-> in_req_s1)
        else $error("in_ack_s1 rose while in_req_s1 was low");

endmodule

bind dll_track_top dll_track_chk u_chk (
    .phi1         (phi1),
    .reset_lin_s1 (reset_lin_s1),
    .in_req_s1    (in_req_s1),
    .in_ack_s1    (in_ack_s1),
    .code_out_s1  (code_out_s1),
    .lane_out_s1  (lane_out_s1),
    .out_req_s1   (out_req_s1),
    .out_ack_s1   (out_ack_s1)
);

`default_nettype wire

// File: verif/dll_track_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dll_track_tb import loop_cfg_pkg::*; ();

    // long enough for a held lane to reach a rail and stay there
    localparam int ROUNDS      = 400;
    localparam int RESET_ROUND = 200;
    localparam int TIMEOUT_CYC = ROUNDS * 100 + 50;
    localparam int CODE_MAX    = (1 << CODE_W) - 1;

    logic              phi1;
    logic              reset_lin_s1;
    logic              in_req_s1;
    logic [LANES-1:0]  up_in_s1;
    logic              in_ack_s1;
    logic [CODE_W-1:0] code_out_s1;
    logic [1:0]        lane_out_s1;
    logic              settle_out_s1;
    logic              out_req_s1;
    logic              out_ack_s1;

    // lane model, 0 to 4 are stepping states, 5 to 8 settling
    int model_state [LANES];
    int model_pend  [LANES];
    int model_code  [LANES];

    logic [CODE_W-1:0] exp_code   [$];
    logic              exp_settle [$];
    int                delivered = 0;
    int                acks_seen = 0;
    int                cycles    = 0;
    logic              ack_prev  = 1'b0;

    dll_track_top uut (
        .phi1          (phi1),
        .reset_lin_s1  (reset_lin_s1),
        .in_req_s1     (in_req_s1),
        .up_in_s1      (up_in_s1),
        .in_ack_s1     (in_ack_s1),
        .code_out_s1   (code_out_s1),
        .lane_out_s1   (lane_out_s1),
        .settle_out_s1 (settle_out_s1),
        .out_req_s1    (out_req_s1),
        .out_ack_s1    (out_ack_s1)
    );

    initial
    begin
        phi1 = 1'b0;
        forever #4 phi1 = ~phi1;
    end

    // ****************************************
    // reference model
    // ****************************************
    function automatic int step_size(input int state);
        case (state)
            1: return 16;
            2: return 8;
            3: return 4;
            4: return 1;
            default: return 0;
        endcase
    endfunction

    function automatic void reset_model();
        for (int l = 0; l < LANES; l++)
        begin
            model_state[l] = 0;
            model_pend[l]  = 1;
            model_code[l]  = CODE_INIT;
        end
    endfunction

    // one sample into one lane, gives {settle, code} seen on the output link
    function automatic logic [CODE_W:0] predict_lane(input int lane, input logic up);
        int   cur;
        int   next_state;
        int   code;
        logic settle;
        cur    = model_state[lane];
        settle = (cur >= 5);
        code   = model_code[lane] + (up ? step_size(cur) : -step_size(cur));
        if (code < 0)
            code = 0;
        else if (code > CODE_MAX)
            code = CODE_MAX;
        if (cur == 0)
            next_state = 1;
        else if (cur <= 4)
        begin
            next_state       = 5;
            model_pend[lane] = (cur == 4) ? 4 : cur + 1;
        end
        else if (cur == 8)
            next_state = model_pend[lane];
        else
            next_state = cur + 1;
        model_state[lane] = next_state;
        model_code[lane]  = code;
        return {settle, code[CODE_W-1:0]};
    endfunction

    task automatic stop_on_failure();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want)
        begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, want);
            stop_on_failure();
        end
    endtask

    task automatic send_round(input logic [LANES-1:0] up);
        @(posedge phi1);
        #1;
        up_in_s1  = up;
        in_req_s1 = 1'b1;
        do
            @(posedge phi1);
        while (in_ack_s1 !== 1'b1);
        #1 in_req_s1 = 1'b0;
        do
            @(posedge phi1);
        while (in_ack_s1 !== 1'b0);
    endtask

    task automatic apply_reset();
        @(posedge phi1);
        #1 reset_lin_s1 = 1'b1;
        reset_model();
        repeat (8) @(posedge phi1);
        #1 reset_lin_s1 = 1'b0;
    endtask

    // ****************************************
    // stimulus
    // ****************************************
    initial
    begin
        logic [LANES-1:0] up;
        logic [CODE_W:0]  predicted;
        void'($urandom(16680));
        reset_lin_s1 = 1'b1;
        in_req_s1    = 1'b0;
        up_in_s1     = '0;
        out_ack_s1   = 1'b0;
        reset_model();
        repeat (8) @(posedge phi1);
        #1 reset_lin_s1 = 1'b0;
        for (int r = 0; r < ROUNDS; r++)
        begin
            if (r == RESET_ROUND)
                apply_reset();
            up = LANES'($urandom);
            // lane 3 held up into the top rail, then down into the bottom one
            up[LANES-1] = (r < RESET_ROUND);
            for (int l = 0; l < LANES; l++)
            begin
                predicted = predict_lane(l, up[l]);
                exp_code.push_back(predicted[CODE_W-1:0]);
                exp_settle.push_back(predicted[CODE_W]);
            end
            send_round(up);
        end
        check_value("rounds_acked", acks_seen, ROUNDS);
        check_value("lanes_delivered", delivered, ROUNDS * LANES);
        $display("RESULT: PASS");
        $finish;
    end

    // output link sink, compares every lane it receives
    initial
    begin
        int gap;
        forever
        begin
            do
                @(posedge phi1);
            while (out_req_s1 !== 1'b1);
            if (exp_code.size() == 0)
            begin
                $display("a lane code arrived with no sample round outstanding");
                stop_on_failure();
            end
            check_value("lane_out_s1", lane_out_s1, delivered % LANES);
            check_value("code_out_s1", code_out_s1, exp_code.pop_front());
            check_value("settle_out_s1", settle_out_s1, exp_settle.pop_front());
            delivered++;
            gap = $urandom % 4;
            repeat (gap) @(posedge phi1);
            #1 out_ack_s1 = 1'b1;
            do
                @(posedge phi1);
            while (out_req_s1 !== 1'b0);
            gap = $urandom % 4;
            repeat (gap) @(posedge phi1);
            #1 out_ack_s1 = 1'b0;
        end
    end

    // in_ack_s1 rises once per round, only after all four lanes
    initial
    begin
        forever
        begin
            @(posedge phi1);
            if ((in_ack_s1 === 1'b1) && (ack_prev !== 1'b1))
            begin
                acks_seen++;
                check_value("lanes_at_in_ack", delivered, acks_seen * LANES);
            end
            ack_prev = in_ack_s1;
        end
    end

    initial
    begin
        while (cycles < TIMEOUT_CYC)
        begin
            @(posedge phi1);
            cycles++;
        end
        $display("timeout after %0d cycles, a handshake hung", cycles);
        stop_on_failure();
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/loop_cfg_pkg.sv
logic/hs_pkg.sv
logic/sample_bus_if.sv
logic/code_bus_if.sv
logic/sample_dispatch.sv
logic/step_fsm.sv
logic/delay_lane.sv
logic/code_collect.sv
logic/dll_track_top.sv
verif/dll_track_chk.sv
verif/dll_track_tb.sv
